/* src/array_ctl_pkg.sv */
// shared codes, register offsets and word types for the array controller, imported by all modules
package array_ctl_pkg;

  // block select, taken from cpu_addr[16:15]
  localparam logic [1:0] bram_select_controller = 2'd0;
  localparam logic [1:0] bram_select_mod        = 2'd1;
  localparam logic [1:0] bram_select_normal     = 2'd2;
  localparam logic [1:0] bram_select_stm        = 2'd3;

  // controller register offsets (word address)
  localparam logic [13:0] addr_ctl_flag       = 14'h0000;
  localparam logic [13:0] addr_mod_mem_page   = 14'h0020;
  localparam logic [13:0] addr_mod_cycle      = 14'h0021;
  localparam logic [13:0] addr_mod_freq_div_0 = 14'h0022;
  localparam logic [13:0] addr_mod_freq_div_1 = 14'h0023;
  localparam logic [13:0] addr_silent_step    = 14'h002d;

  // bits of the flag register
  localparam int ctl_flag_force_fan_bit = 4;
  localparam int ctl_flag_sync_bit      = 8;

  // duty/phase table entry
  // the CPU writes the raw word, the scanner splits it
  typedef union packed {
    logic [15:0] raw;
    struct packed {
      logic [7:0] duty;   // high byte
      logic [7:0] phase;  // low byte
    } dp;
  } duty_phase_word_t;

endpackage

/* src/cpu_bus_decoder.sv */
// samples the CPU bus, issues one write strobe per write cycle and returns register read data
`timescale 1ns/1ps
module cpu_bus_decoder (
  input  logic        CPU_CKIO,
  input  logic        rst_n,
  input  logic        cpu_cs1_n,
  input  logic        cpu_we0_n,
  input  logic [16:0] cpu_addr,
  input  logic [15:0] cpu_data,
  input  logic [15:0] ctl_rd_data,
  input  logic [15:0] table_rd_data,
  output logic        wr_en,
  output logic [1:0]  wr_select,
  output logic [13:0] wr_addr,
  output logic [15:0] wr_data,
  output logic [13:0] rd_addr,
  output logic [15:0] cpu_data_read
);
  import array_ctl_pkg::*;

  logic        cs_n_q;
  logic        we_n_q;
  logic        we_n_d;   // previous sample of we, for the edge
  logic [16:0] addr_q;
  logic [15:0] data_q;
  logic [1:0]  rd_sel_q; // select of the word now in the read registers

  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      cs_n_q   <= 1'b1;
      we_n_q   <= 1'b1;
      we_n_d   <= 1'b1;
      wr_en    <= 1'b0;
      rd_sel_q <= bram_select_controller;
    end else begin
      cs_n_q   <= cpu_cs1_n;
      we_n_q   <= cpu_we0_n;
      we_n_d   <= we_n_q;
      wr_en    <= ~cs_n_q & ~we_n_q & we_n_d;  // falling edge of we while selected
      rd_sel_q <= addr_q[16:15];
    end
  end

  // payload, no reset
  always_ff @(posedge CPU_CKIO) begin
    addr_q <= cpu_addr;
    data_q <= cpu_data;
  end

  assign wr_select = addr_q[16:15];
  assign wr_addr   = addr_q[14:1];
  assign wr_data   = data_q;
  assign rd_addr   = addr_q[14:1];

  always_comb begin
    case (rd_sel_q)
      bram_select_controller: cpu_data_read = ctl_rd_data;
      bram_select_normal:     cpu_data_read = table_rd_data;
      default:                cpu_data_read = '0;  // mod and stm are write only
    endcase
  end

endmodule

/* src/ctl_regs.sv */
// controller register bank: flags, modulation cycle, divider and page, written and read by the CPU
`timescale 1ns/1ps
module ctl_regs (
  input  logic        CPU_CKIO,
  input  logic        rst_n,
  input  logic        wr_en,
  input  logic [1:0]  wr_select,
  input  logic [13:0] wr_addr,
  input  logic [15:0] wr_data,
  input  logic [13:0] rd_addr,
  output logic [15:0] rd_data,
  output logic        sync,
  output logic        force_fan,
  output logic        mod_mem_page,
  output logic [15:0] mod_cycle,
  output logic [31:0] mod_freq_div,
  output logic [15:0] silent_step
);
  import array_ctl_pkg::*;

  logic [15:0] ctl_flag;
  logic [15:0] freq_div_lo;
  logic [15:0] freq_div_hi;
  logic        reg_wr;

  assign reg_wr = wr_en && (wr_select == bram_select_controller);

  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      ctl_flag     <= '0;
      mod_mem_page <= 1'b0;
      mod_cycle    <= '0;
      freq_div_lo  <= '0;
      freq_div_hi  <= '0;
      silent_step  <= '0;
    end else if (reg_wr) begin
      case (wr_addr)
        addr_ctl_flag:       ctl_flag     <= wr_data;
        addr_mod_mem_page:   mod_mem_page <= wr_data[0];
        addr_mod_cycle:      mod_cycle    <= wr_data;
        addr_mod_freq_div_0: freq_div_lo  <= wr_data;
        addr_mod_freq_div_1: freq_div_hi  <= wr_data;
        addr_silent_step:    silent_step  <= wr_data;
        default: ;  // unmapped offsets are dropped
      endcase
    end
  end

  // read port, one cycle latency
  always_ff @(posedge CPU_CKIO) begin
    case (rd_addr)
      addr_ctl_flag:       rd_data <= ctl_flag;
      addr_mod_mem_page:   rd_data <= {15'd0, mod_mem_page};
      addr_mod_cycle:      rd_data <= mod_cycle;
      addr_mod_freq_div_0: rd_data <= freq_div_lo;
      addr_mod_freq_div_1: rd_data <= freq_div_hi;
      addr_silent_step:    rd_data <= silent_step;
      default:             rd_data <= '0;
    endcase
  end

  assign mod_freq_div = {freq_div_hi, freq_div_lo};
  assign sync         = ctl_flag[ctl_flag_sync_bit];
  assign force_fan    = ctl_flag[ctl_flag_force_fan_bit];

endmodule

/* src/mod_mem.sv */
// two-page modulation sample memory, CPU writes whole words and the sequencer reads single bytes
`timescale 1ns/1ps
module mod_mem #(
  parameter int mod_addr_width = 14
) (
  input  logic                      CPU_CKIO,
  input  logic                      wr_en,
  input  logic [1:0]                wr_select,
  input  logic [13:0]               wr_addr,
  input  logic [15:0]               wr_data,
  input  logic                      mod_mem_page,
  input  logic [mod_addr_width+1:0] rd_addr,
  output logic [7:0]                rd_data
);
  import array_ctl_pkg::*;

  localparam int depth = 2 << mod_addr_width;  // both pages

  logic [15:0] mem [depth];
  logic [15:0] word_q;
  logic        byte_sel_q;

  always_ff @(posedge CPU_CKIO) begin
    if (wr_en && (wr_select == bram_select_mod)) begin
      mem[{mod_mem_page, wr_addr[mod_addr_width-1:0]}] <= wr_data;
    end
  end

  // sample index: upper bits pick the word, bit 0 the byte
  always_ff @(posedge CPU_CKIO) begin
    word_q     <= mem[rd_addr[mod_addr_width+1:1]];
    byte_sel_q <= rd_addr[0];
  end

  assign rd_data = byte_sel_q ? word_q[15:8] : word_q[7:0];

endmodule

/* src/mod_sequencer.sv */
// modulation sequencer, steps the sample index every mod_freq_div cycles and wraps at mod_cycle
`timescale 1ns/1ps
module mod_sequencer #(
  parameter int mod_addr_width = 14
) (
  input  logic                      CPU_CKIO,
  input  logic                      rst_n,
  input  logic [15:0]               mod_cycle,
  input  logic [31:0]               mod_freq_div,
  input  logic [7:0]                mem_data,
  output logic [mod_addr_width+1:0] mem_addr,
  output logic [15:0]               mod_idx,
  output logic [7:0]                mod_value
);

  logic [31:0] div_cnt;
  logic [31:0] div_last;  // last count before a step

  // a divider of 0 behaves as 1
  assign div_last = (mod_freq_div == '0) ? 32'd0 : mod_freq_div - 32'd1;

  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      div_cnt <= '0;
      mod_idx <= '0;
    end else if (div_cnt >= div_last) begin
      div_cnt <= '0;
      if (mod_idx >= mod_cycle) begin
        mod_idx <= '0;
      end else begin
        mod_idx <= mod_idx + 16'd1;
      end
    end else begin
      div_cnt <= div_cnt + 32'd1;
    end
  end

  assign mem_addr  = mod_idx[mod_addr_width+1:0];
  assign mod_value = mem_data;  // memory already adds the cycle of latency

endmodule

/* src/duty_phase_table.sv */
// per-transducer duty/phase table with a CPU read port and a scanner that runs while sync is set
`timescale 1ns/1ps
module duty_phase_table #(
  parameter int num_trans = 249
) (
  input  logic        CPU_CKIO,
  input  logic        rst_n,
  input  logic        wr_en,
  input  logic [1:0]  wr_select,
  input  logic [13:0] wr_addr,
  input  logic [15:0] wr_data,
  input  logic [13:0] rd_addr,
  input  logic        sync,
  output logic [15:0] rd_data,
  output logic [7:0]  tr_idx,
  output logic [7:0]  duty,
  output logic [7:0]  phase
);
  import array_ctl_pkg::*;

  duty_phase_word_t mem [num_trans];
  duty_phase_word_t scan_q;

  always_ff @(posedge CPU_CKIO) begin
    if (wr_en && (wr_select == bram_select_normal) && (wr_addr < 14'(num_trans))) begin
      mem[wr_addr[7:0]].raw <= wr_data;
    end
  end

  // CPU read, out of range reads zero
  always_ff @(posedge CPU_CKIO) begin
    if (rd_addr < 14'(num_trans)) begin
      rd_data <= mem[rd_addr[7:0]].raw;
    end else begin
      rd_data <= '0;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      tr_idx <= '0;
    end else if (sync) begin
      if (tr_idx == 8'(num_trans - 1)) begin
        tr_idx <= '0;
      end else begin
        tr_idx <= tr_idx + 8'd1;
      end
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    scan_q <= mem[tr_idx];
  end

  assign duty  = scan_q.dp.duty;
  assign phase = scan_q.dp.phase;

endmodule

/* src/array_ctl_top.sv */
// top level of the CPU memory interface, ties the bus decoder to registers, memories and sequencer
`timescale 1ns/1ps
module array_ctl_top #(
  parameter int num_trans      = 249,
  parameter int mod_addr_width = 14
) (
  input  logic        CPU_CKIO,
  input  logic        rst_n,
  input  logic        cpu_cs1_n,
  input  logic        cpu_we0_n,
  input  logic [16:0] cpu_addr,
  input  logic [15:0] cpu_data,
  output logic [15:0] cpu_data_read,
  output logic        force_fan,
  output logic [15:0] mod_idx,
  output logic [7:0]  mod_value,
  output logic [7:0]  tr_idx,
  output logic [7:0]  duty,
  output logic [7:0]  phase
);

  logic                      wr_en;
  logic [1:0]                wr_select;
  logic [13:0]               wr_addr;
  logic [15:0]               wr_data;
  logic [13:0]               rd_addr;
  logic [15:0]               ctl_rd_data;
  logic [15:0]               table_rd_data;
  logic                      sync;
  logic                      mod_mem_page;
  logic [15:0]               mod_cycle;
  logic [31:0]               mod_freq_div;
  logic [mod_addr_width+1:0] mod_rd_addr;
  logic [7:0]                mod_rd_data;

  cpu_bus_decoder u_decoder (
    .CPU_CKIO     (CPU_CKIO),
    .rst_n        (rst_n),
    .cpu_cs1_n    (cpu_cs1_n),
    .cpu_we0_n    (cpu_we0_n),
    .cpu_addr     (cpu_addr),
    .cpu_data     (cpu_data),
    .ctl_rd_data  (ctl_rd_data),
    .table_rd_data(table_rd_data),
    .wr_en        (wr_en),
    .wr_select    (wr_select),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .rd_addr      (rd_addr),
    .cpu_data_read(cpu_data_read)
  );

  // silent_step only reaches the CPU read port, the silencer is not part of this block
  ctl_regs u_ctl_regs (
    .CPU_CKIO    (CPU_CKIO),
    .rst_n       (rst_n),
    .wr_en       (wr_en),
    .wr_select   (wr_select),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .rd_addr     (rd_addr),
    .rd_data     (ctl_rd_data),
    .sync        (sync),
    .force_fan   (force_fan),
    .mod_mem_page(mod_mem_page),
    .mod_cycle   (mod_cycle),
    .mod_freq_div(mod_freq_div),
    .silent_step ()
  );

  mod_mem #(.mod_addr_width(mod_addr_width)) u_mod_mem (
    .CPU_CKIO    (CPU_CKIO),
    .wr_en       (wr_en),
    .wr_select   (wr_select),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .mod_mem_page(mod_mem_page),
    .rd_addr     (mod_rd_addr),
    .rd_data     (mod_rd_data)
  );

  mod_sequencer #(.mod_addr_width(mod_addr_width)) u_mod_seq (
    .CPU_CKIO    (CPU_CKIO),
    .rst_n       (rst_n),
    .mod_cycle   (mod_cycle),
    .mod_freq_div(mod_freq_div),
    .mem_data    (mod_rd_data),
    .mem_addr    (mod_rd_addr),
    .mod_idx     (mod_idx),
    .mod_value   (mod_value)
  );

  duty_phase_table #(.num_trans(num_trans)) u_table (
    .CPU_CKIO (CPU_CKIO),
    .rst_n    (rst_n),
    .wr_en    (wr_en),
    .wr_select(wr_select),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_addr  (rd_addr),
    .sync     (sync),
    .rd_data  (table_rd_data),
    .tr_idx   (tr_idx),
    .duty     (duty),
    .phase    (phase)
  );

endmodule

/* bench/cpu_bus_driver.sv */
// CPU bus master for the testbench, write and read tasks that follow the CPU cycle timing
`timescale 1ns/1ps
module cpu_bus_driver (
  input  logic        CPU_CKIO,
  input  logic [15:0] cpu_data_read,
  output logic        cpu_cs1_n,
  output logic        cpu_we0_n,
  output logic [16:0] cpu_addr,
  output logic [15:0] cpu_data
);

  // bus idle until the first cycle
  initial begin
    cpu_cs1_n = 1'b1;
    cpu_we0_n = 1'b1;
    cpu_addr  = '0;
    cpu_data  = '0;
  end

  // one write cycle, returns once the word has landed in the target
  task automatic bus_write(input logic [16:0] addr, input logic [15:0] data);
    @(posedge CPU_CKIO);
    #1;
    cpu_addr  = addr;
    cpu_data  = data;
    cpu_cs1_n = 1'b0;
    @(posedge CPU_CKIO);
    #1;
    cpu_we0_n = 1'b0;
    repeat (2) @(posedge CPU_CKIO);  // we low for two cycles
    #1;
    cpu_we0_n = 1'b1;
    cpu_cs1_n = 1'b1;
    @(posedge CPU_CKIO);  // strobe from the decoder lands here
  endtask

  // address, three cycles, then take the read data
  task automatic bus_read(input logic [16:0] addr, output logic [15:0] data);
    @(posedge CPU_CKIO);
    #1;
    cpu_addr  = addr;
    cpu_cs1_n = 1'b0;
    cpu_we0_n = 1'b1;
    repeat (3) @(posedge CPU_CKIO);
    #1;
    data      = cpu_data_read;
    cpu_cs1_n = 1'b1;
  endtask

endmodule

/* bench/array_ctl_assertions.sv */
// bound checks on the decoder write strobe and the transducer scan index
`timescale 1ns/1ps
module array_ctl_assertions #(
  parameter int num_trans = 249
) (
  input logic       CPU_CKIO,
  input logic       rst_n,
  input logic       wr_en,
  input logic [7:0] tr_idx,
  input logic       sync
);

  // one strobe per write cycle
  wr_en_single: assert property (@(posedge CPU_CKIO) disable iff (!rst_n) wr_en |=> !wr_en)
    else $error("wr_en high on two cycles in a row");

  tr_idx_range: assert property (@(posedge CPU_CKIO) disable iff (!rst_n)
    tr_idx < 8'(num_trans))
    else $error("tr_idx beyond the last transducer");

  tr_idx_hold: assert property (@(posedge CPU_CKIO) disable iff (!rst_n)
    !sync |=> $stable(tr_idx))
    else $error("tr_idx moved while sync was low");

endmodule

// decoder strobe and scanner index meet in the top level
bind array_ctl_top array_ctl_assertions #(.num_trans(num_trans)) u_ctl_sva (
  .CPU_CKIO(CPU_CKIO),
  .rst_n   (rst_n),
  .wr_en   (wr_en),
  .tr_idx  (tr_idx),
  .sync    (sync)
);

/* bench/array_ctl_tb.sv */
// testbench for array_ctl_top, directed tests of registers, duty/phase table and modulation playback
`timescale 1ns/1ps
module array_ctl_tb;
  import array_ctl_pkg::*;

  localparam int num_trans      = 249;
  localparam int mod_addr_width = 4;   // small pages so playback crosses a page quickly
  localparam int page_words     = 1 << mod_addr_width;
  localparam int clk_period     = 8;
  localparam int write_cycles   = 5;
  localparam int read_cycles    = 4;
  localparam int t1_cycles = 8 * read_cycles;
  localparam int t2_cycles = 8 * write_cycles + 20 * read_cycles;
  localparam int t3_cycles = num_trans * (write_cycles + read_cycles) + 2 * write_cycles
                             + num_trans + 20;
  localparam int t4_cycles = (page_words + 4) * write_cycles + 2 * (2 * page_words + 2) * 5 + 20;
  localparam int t5_cycles = (page_words + 4) * write_cycles + 6 * read_cycles
                             + 8 * page_words + 20;
  localparam int test_cycles = t1_cycles + t2_cycles + t3_cycles + t4_cycles + t5_cycles;
  localparam int watchdog_ns = 2 * (test_cycles + 3) * clk_period;

  logic        CPU_CKIO;
  logic        rst_n;
  logic        cpu_cs1_n;
  logic        cpu_we0_n;
  logic [16:0] cpu_addr;
  logic [15:0] cpu_data;
  logic [15:0] cpu_data_read;
  logic        force_fan;
  logic [15:0] mod_idx;
  logic [7:0]  mod_value;
  logic [7:0]  tr_idx;
  logic [7:0]  duty;
  logic [7:0]  phase;

  logic [31:0] lfsr_state;
  logic [15:0] exp_flag;
  logic [15:0] exp_page;
  logic [15:0] exp_cycle;
  logic [15:0] exp_div0;
  logic [15:0] exp_div1;
  logic [15:0] exp_silent;
  logic [15:0] table_model [num_trans];
  logic [7:0]  mod_samples [4 << mod_addr_width];  // both pages, one byte per sample

  array_ctl_top #(
    .num_trans     (num_trans),
    .mod_addr_width(mod_addr_width)
  ) UUT (
    .CPU_CKIO     (CPU_CKIO),
    .rst_n        (rst_n),
    .cpu_cs1_n    (cpu_cs1_n),
    .cpu_we0_n    (cpu_we0_n),
    .cpu_addr     (cpu_addr),
    .cpu_data     (cpu_data),
    .cpu_data_read(cpu_data_read),
    .force_fan    (force_fan),
    .mod_idx      (mod_idx),
    .mod_value    (mod_value),
    .tr_idx       (tr_idx),
    .duty         (duty),
    .phase        (phase)
  );

  cpu_bus_driver u_driver (
    .CPU_CKIO     (CPU_CKIO),
    .cpu_data_read(cpu_data_read),
    .cpu_cs1_n    (cpu_cs1_n),
    .cpu_we0_n    (cpu_we0_n),
    .cpu_addr     (cpu_addr),
    .cpu_data     (cpu_data)
  );

  initial begin
    CPU_CKIO = 1'b0;
    forever #(clk_period / 2) CPU_CKIO = ~CPU_CKIO;
  end

  initial begin
    #(watchdog_ns);
    abort_run("timeout, the tests did not finish in the expected time");
  end

  initial begin
    rst_n      = 1'b0;
    lfsr_state = 32'h8fff;
    exp_flag   = '0;
    exp_page   = '0;
    exp_cycle  = '0;
    exp_div0   = '0;
    exp_div1   = '0;
    exp_silent = '0;
    repeat (3) @(posedge CPU_CKIO);
    #1;
    rst_n = 1'b1;
    test_reset_state();
    test_registers();
    test_duty_phase_table();
    test_mod_playback();
    test_page_switch();
    $display("All tests passed!");
    $finish;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  // one step per bit taken
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[14:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic [16:0] bus_addr(input logic [1:0] sel, input logic [13:0] off);
    return {sel, off, 1'b0};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("[FAIL] t=%0t %s got 0x%0h expected 0x%0h",
                          $time, name, actual, expected));
    end
  endtask

  task automatic write_reg(input logic [13:0] off, input logic [15:0] data);
    u_driver.bus_write(bus_addr(bram_select_controller, off), data);
  endtask

  task automatic check_reg(input string name, input logic [13:0] off,
                           input logic [15:0] expected);
    logic [15:0] v;
    u_driver.bus_read(bus_addr(bram_select_controller, off), v);
    check(name, 32'(v), 32'(expected));
  endtask

  task automatic check_regs;
    check_reg("ctl_flag", addr_ctl_flag, exp_flag);
    check_reg("mod_mem_page", addr_mod_mem_page, exp_page);
    check_reg("mod_cycle", addr_mod_cycle, exp_cycle);
    check_reg("mod_freq_div_0", addr_mod_freq_div_0, exp_div0);
    check_reg("mod_freq_div_1", addr_mod_freq_div_1, exp_div1);
    check_reg("silent_step", addr_silent_step, exp_silent);
  endtask

  task automatic write_mod_word(input int page, input int addr, input logic [15:0] data);
    int base;
    base = 2 * ((page << mod_addr_width) + addr);
    mod_samples[base]     = data[7:0];   // even sample in the low byte
    mod_samples[base + 1] = data[15:8];
    u_driver.bus_write(bus_addr(bram_select_mod, 14'(addr)), data);
  endtask

  // follows mod_idx and mod_value for n cycles
  task automatic watch_playback(input int div, input int cyc, input int n);
    logic [15:0] prev_idx;
    int          run;
    int          wraps;
    bit          first;
    repeat (2 * div + 4) @(posedge CPU_CKIO);  // let a stale index wrap back
    @(negedge CPU_CKIO);
    prev_idx = mod_idx;
    run      = 1;
    wraps    = 0;
    first    = 1'b1;
    repeat (n) begin
      @(negedge CPU_CKIO);
      check("mod_value", 32'(mod_value), 32'(mod_samples[prev_idx[mod_addr_width+1:0]]));
      if (mod_idx != prev_idx) begin
        check("mod_idx", 32'(mod_idx),
              (prev_idx == 16'(cyc)) ? 32'd0 : 32'(prev_idx) + 32'd1);
        if (!first) begin
          check("mod_idx step spacing", 32'(run), 32'(div));
        end
        if (mod_idx == 16'd0) begin
          wraps++;
        end
        first = 1'b0;
        run   = 1;
      end else begin
        run++;
      end
      prev_idx = mod_idx;
    end
    if (wraps == 0) begin
      abort_run("mod_idx never wrapped back to zero");
    end
  endtask

  task automatic test_reset_state;
    logic [15:0] v;
    @(negedge CPU_CKIO);
    check("force_fan", 32'(force_fan), 32'd0);
    check("tr_idx", 32'(tr_idx), 32'd0);
    check("mod_idx", 32'(mod_idx), 32'd0);
    check_regs();
    u_driver.bus_read(bus_addr(bram_select_controller, 14'h0001), v);  // unmapped
    check("unmapped register", 32'(v), 32'd0);
  endtask

  task automatic test_registers;
    logic [15:0] v;
    exp_cycle  = rand_bits(16);
    exp_div0   = rand_bits(16);
    exp_div1   = rand_bits(16);
    exp_silent = rand_bits(16);
    write_reg(addr_mod_cycle, exp_cycle);
    write_reg(addr_mod_freq_div_0, exp_div0);
    write_reg(addr_mod_freq_div_1, exp_div1);
    write_reg(addr_silent_step, exp_silent);
    check_regs();
    exp_flag = '0;
    exp_flag[ctl_flag_force_fan_bit] = 1'b1;
    write_reg(addr_ctl_flag, exp_flag);
    @(negedge CPU_CKIO);
    check("force_fan", 32'(force_fan), 32'd1);
    check_reg("ctl_flag", addr_ctl_flag, exp_flag);
    exp_flag = '0;
    write_reg(addr_ctl_flag, exp_flag);
    @(negedge CPU_CKIO);
    check("force_fan", 32'(force_fan), 32'd0);
    // STM writes at register offsets
    u_driver.bus_write(bus_addr(bram_select_stm, addr_mod_cycle), ~exp_cycle);
    u_driver.bus_write(bus_addr(bram_select_stm, addr_ctl_flag), 16'hffff);
    @(negedge CPU_CKIO);
    check("force_fan", 32'(force_fan), 32'd0);
    check_regs();
    u_driver.bus_read(bus_addr(bram_select_stm, addr_mod_cycle), v);
    check("stm read", 32'(v), 32'd0);
  endtask

  task automatic test_duty_phase_table;
    logic [15:0] v;
    logic [7:0]  prev_idx;
    for (int i = 0; i < num_trans; i++) begin
      table_model[i] = rand_bits(16);
      u_driver.bus_write(bus_addr(bram_select_normal, 14'(i)), table_model[i]);
    end
    for (int i = 0; i < num_trans; i++) begin
      u_driver.bus_read(bus_addr(bram_select_normal, 14'(i)), v);
      check("table word", 32'(v), 32'(table_model[i]));
    end
    exp_flag = '0;
    exp_flag[ctl_flag_sync_bit] = 1'b1;
    write_reg(addr_ctl_flag, exp_flag);
    @(negedge CPU_CKIO);
    prev_idx = tr_idx;
    repeat (num_trans + 10) begin
      @(negedge CPU_CKIO);
      check("tr_idx", 32'(tr_idx),
            (prev_idx == 8'(num_trans - 1)) ? 32'd0 : 32'(prev_idx) + 32'd1);
      check("duty", 32'(duty), 32'(table_model[prev_idx][15:8]));
      check("phase", 32'(phase), 32'(table_model[prev_idx][7:0]));
      prev_idx = tr_idx;
    end
    exp_flag = '0;
    write_reg(addr_ctl_flag, exp_flag);
    @(negedge CPU_CKIO);
    prev_idx = tr_idx;
    repeat (4) begin
      @(negedge CPU_CKIO);
      check("tr_idx held", 32'(tr_idx), 32'(prev_idx));
    end
  endtask

  task automatic test_mod_playback;
    int div;
    int cyc;
    div = 2 + int'(rand_bits(2));
    cyc = 2 * page_words - 1 - int'(rand_bits(3));  // stays inside page 0
    for (int a = 0; a < page_words; a++) begin
      write_mod_word(0, a, rand_bits(16));
    end
    exp_div1  = '0;
    exp_div0  = 16'(div);
    exp_cycle = 16'(cyc);
    write_reg(addr_mod_freq_div_1, exp_div1);
    write_reg(addr_mod_freq_div_0, exp_div0);
    write_reg(addr_mod_cycle, exp_cycle);
    watch_playback(div, cyc, 2 * (cyc + 2) * div);
  endtask

  task automatic test_page_switch;
    exp_page = 16'd1;
    write_reg(addr_mod_mem_page, exp_page);
    for (int a = 0; a < page_words; a++) begin
      write_mod_word(1, a, rand_bits(16));
    end
    exp_div0  = 16'd1;
    exp_cycle = 16'(4 * page_words - 1);  // run through both pages
    write_reg(addr_mod_freq_div_0, exp_div0);
    write_reg(addr_mod_cycle, exp_cycle);
    check_regs();
    watch_playback(1, 4 * page_words - 1, 8 * page_words + 8);
  endtask

endmodule

/* flist.f */
src/array_ctl_pkg.sv
src/cpu_bus_decoder.sv
src/ctl_regs.sv
src/mod_mem.sv
src/mod_sequencer.sv
src/duty_phase_table.sv
src/array_ctl_top.sv
bench/cpu_bus_driver.sv
bench/array_ctl_assertions.sv
bench/array_ctl_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = array_ctl_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
